/* logic/sw_score_pkg.sv */
// scoring types for the Smith-Waterman array; score arithmetic wraps at SCORE_W bits, no saturation

package sw_score_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////
    localparam int SCORE_W = 10;    // signed score, range -512..511
    localparam int BASE_W  = 2;     // one nucleotide, A/C/G/T as 0..3

    //////////////////////////////
    // scalar types
    //////////////////////////////
    typedef logic signed [SCORE_W-1:0] score_t;   // H, E, F and best scores
    typedef logic [BASE_W-1:0]         base_t;    // query or target base

    // substitution and gap weights, held stable during an alignment
    // match is positive, mismatch and gap_open negative
    typedef struct packed {
        score_t match;      // added on equal bases
        score_t mismatch;   // added on differing bases
        score_t gap_open;   // linear gap, applied per gap base
    } scoring_t;

    //////////////////////////////
    // traceback codes
    //////////////////////////////
    // which neighbour produced H for a cell
    // TB_H also marks a pass-through cell (query disabled)
    typedef enum logic [1:0] {
        TB_NONE = 2'd0,     // not inside a target
        TB_E    = 2'd1,     // left gap won
        TB_F    = 2'd2,     // upper gap won
        TB_H    = 2'd3      // diagonal won
    } trace_e;

endpackage : sw_score_pkg

/* logic/sw_array_pkg.sv */
// array geometry and inter-cell words; Q_CELLS must fit the QPOS_W index, no check is made

package sw_array_pkg;

    //////////////////////////////
    // geometry
    //////////////////////////////
    localparam int Q_CELLS = 8;     // query bases, one per cell
    localparam int QPOS_W  = 3;     // clog2 of Q_CELLS

    typedef logic [QPOS_W-1:0] qpos_t;  // query row index of a cell

    //////////////////////////////
    // words passed along the chain
    //////////////////////////////

    // one target column, moves one cell per enabled cycle
    typedef struct packed {
        sw_score_pkg::base_t base;      // target base of this column
        logic                new_target; // marker column, base ignored
        logic                end_target; // set on the last base column
    } column_t;

    // query word, loaded once per query
    typedef struct packed {
        sw_score_pkg::base_t base;  // query base for the row
        logic                en;    // low -> cell passes h_up through
    } query_t;

    // upper cell -> lower cell, all registered in the upper cell
    typedef struct packed {
        sw_score_pkg::score_t h;          // H of the upper row, same column
        sw_score_pkg::score_t best;       // best local score of rows above
        qpos_t                best_index; // row holding that best score
    } link_t;

endpackage : sw_array_pkg

/* logic/sw_cell_score.sv */
// combinational recurrence of one cell; linear gaps only, sums may wrap if scores exceed SCORE_W
`timescale 1ns/1ps

module sw_cell_score (
    input  sw_array_pkg::query_t   query,      // registered query word
    input  sw_score_pkg::base_t    target,     // target base of the current column
    input  sw_score_pkg::scoring_t scoring,
    input  sw_score_pkg::score_t   h_diag,     // H[i-1][j-1]
    input  sw_score_pkg::score_t   h_up,       // H[i-1][j]
    input  sw_score_pkg::score_t   h_left,     // H[i][j-1]
    output sw_score_pkg::score_t   next_h,     // H[i][j]
    output sw_score_pkg::trace_e   next_trace
);

    import sw_score_pkg::*;

    score_t sub;        // match or mismatch weight
    score_t diag;       // diagonal candidate
    score_t gap_e;      // left gap candidate, clipped
    score_t gap_f;      // upper gap candidate, clipped
    score_t max_gap;    // max(E, F)
    trace_e gap_trace;  // which gap gave max_gap

    //////////////////////////////
    // candidates
    //////////////////////////////
    always_comb begin
        sub   = (query.base == target) ? scoring.match : scoring.mismatch;
        diag  = h_diag + sub;
        gap_e = h_left + scoring.gap_open;
        gap_f = h_up + scoring.gap_open;
        // local alignment, gaps never go below zero
        if (gap_e[SCORE_W-1]) begin
            gap_e = '0;
        end
        if (gap_f[SCORE_W-1]) begin
            gap_f = '0;
        end
    end

    //////////////////////////////
    // selection
    //////////////////////////////
    always_comb begin
        // F only on a strict win over E
        if (gap_f > gap_e) begin
            max_gap   = gap_f;
            gap_trace = TB_F;
        end else begin
            max_gap   = gap_e;
            gap_trace = TB_E;
        end

        if (!query.en) begin
            next_h     = h_up;      // disabled row is transparent
            next_trace = TB_H;
        end else if (diag >= max_gap) begin
            next_h     = diag;      // diagonal wins ties
            next_trace = TB_H;
        end else begin
            next_h     = max_gap;   // >= 0, so H is clipped at zero too
            next_trace = gap_trace;
        end
    end

endmodule : sw_cell_score

/* logic/sw_local_max.sv */
// running best score of rows 0..INDEX; ties keep the upper row, so the lowest index is reported
`timescale 1ns/1ps

module sw_local_max #(
    parameter int INDEX = 0     // row of the owning cell
) (
    input                         clk,
    input                         rst,
    input                         enable,     // global stall, low holds everything
    input                         clear,      // new target, restart from zero
    input  sw_score_pkg::score_t  up_best,    // best of rows above, same column
    input  sw_array_pkg::qpos_t   up_index,
    input  sw_score_pkg::score_t  next_h,     // this row's new H
    output sw_score_pkg::score_t  best,
    output sw_array_pkg::qpos_t   best_index
);

    import sw_array_pkg::*;

    logic up_wins;      // upper value beats stored and new
    logic own_wins;     // stored value beats new

    // priority upper > stored > new, each on >=
    assign up_wins  = (up_best >= best) && (up_best >= next_h);
    assign own_wins = (best >= next_h);

    //////////////////////////////
    // best register
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            best       <= '0;
            best_index <= '0;
        end else if (enable) begin
            if (clear) begin
                best       <= '0;   // zero is the floor of a local score
                best_index <= '0;
            end else if (up_wins) begin
                best       <= up_best;
                best_index <= up_index;
            end else if (own_wins) begin
                best       <= best;
                best_index <= best_index;
            end else begin
                best       <= next_h;
                best_index <= qpos_t'(INDEX);   // this row now holds the max
            end
        end
    end

endmodule : sw_local_max

/* logic/sw_cell.sv */
// one systolic row; query_load is taken only on enabled cycles, INDEX 0 ignores link_in
`timescale 1ns/1ps

module sw_cell #(
    parameter int INDEX = 0     // query row of this cell
) (
    input                          clk,
    input                          rst,
    input                          enable,        // global stall
    input  sw_score_pkg::scoring_t scoring,
    input                          query_load,    // strobe, latch query_word
    input  sw_array_pkg::query_t   query_word,
    input  sw_array_pkg::column_t  column_in,     // column from the cell above
    input  sw_array_pkg::link_t    link_in,       // H and best from the cell above
    output sw_array_pkg::column_t  column_out,    // column to the cell below
    output sw_array_pkg::link_t    link_out,      // H and best to the cell below
    output sw_score_pkg::trace_e   trace          // direction of the H now on link_out
);

    import sw_score_pkg::*;
    import sw_array_pkg::*;

    query_t query_q;        // loaded query word
    link_t  up_link;        // upper link, zero for the first row
    score_t h_diag_q;       // upper H one column back
    score_t h_q;            // own H, also h_left
    score_t next_h;
    trace_e next_trace;
    logic   trace_valid;    // inside a target
    score_t best;
    qpos_t  best_index;

    // row -1 of the matrix is all zero
    assign up_link = (INDEX == 0) ? '0 : link_in;

    //////////////////////////////
    // recurrence
    //////////////////////////////
    sw_cell_score u_score (
        .query      (query_q),
        .target     (column_in.base),
        .scoring    (scoring),
        .h_diag     (h_diag_q),
        .h_up       (up_link.h),
        .h_left     (h_q),
        .next_h     (next_h),
        .next_trace (next_trace)
    );

    sw_local_max #(
        .INDEX (INDEX)
    ) u_max (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .clear      (column_in.new_target),
        .up_best    (up_link.best),
        .up_index   (up_link.best_index),
        .next_h     (next_h),
        .best       (best),
        .best_index (best_index)
    );

    //////////////////////////////
    // datapath registers
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            query_q    <= '0;
            h_diag_q   <= '0;
            h_q        <= '0;
            column_out <= '0;
        end else if (enable) begin
            if (query_load) begin
                query_q <= query_word;
            end
            h_diag_q   <= up_link.h;    // becomes H[i-1][j-1] next column
            column_out <= column_in;    // one cell per enabled cycle
            if (column_in.new_target) begin
                h_q <= '0;              // H[i][-1] = 0 before the first base
            end else begin
                h_q <= next_h;
            end
        end
    end

    //////////////////////////////
    // traceback
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            trace_valid <= 1'b0;
            trace       <= TB_NONE;
        end else if (enable) begin
            // valid from the column after new_target up to end_target
            if (column_in.new_target) begin
                trace_valid <= 1'b1;
            end else if (column_in.end_target) begin
                trace_valid <= 1'b0;
            end
            if (trace_valid && !column_in.new_target) begin
                trace <= next_trace;
            end else begin
                trace <= TB_NONE;   // marker column or outside a target
            end
        end
    end

    // all fields come straight from registers
    assign link_out = '{h: h_q, best: best, best_index: best_index};

endmodule : sw_cell

/* logic/sw_array.sv */
// linear array of Q_CELLS rows; results of a column appear Q_CELLS enabled cycles after it enters
`timescale 1ns/1ps

module sw_array (
    input                          clk,
    input                          rst,
    input                          enable,        // low stalls the whole chain
    input  sw_score_pkg::scoring_t scoring,
    input                          query_load,    // strobe with query_bases
    input  sw_array_pkg::query_t [sw_array_pkg::Q_CELLS-1:0] query_bases,
    input  sw_array_pkg::column_t  column,        // target column, taken on enable
    output sw_score_pkg::score_t   h_last,        // H of the last row
    output sw_score_pkg::score_t   best_score,    // best local score so far
    output sw_array_pkg::qpos_t    best_index,    // row of best_score
    output sw_score_pkg::trace_e   trace,         // traceback of the last row
    output logic                   done           // end_target leaving the chain
);

    import sw_score_pkg::*;
    import sw_array_pkg::*;

    column_t col_chain  [Q_CELLS+1];   // [i] feeds cell i, [Q_CELLS] leaves the array
    link_t   link_chain [Q_CELLS+1];   // [i] feeds cell i, [0] ignored by cell 0
    trace_e  cell_trace [Q_CELLS];     // per-row traceback

    assign col_chain[0]  = column;
    assign link_chain[0] = '0;

    //////////////////////////////
    // cell chain
    //////////////////////////////
    for (genvar i = 0; i < Q_CELLS; i++) begin : g_cell
        sw_cell #(
            .INDEX (i)
        ) u_cell (
            .clk        (clk),
            .rst        (rst),
            .enable     (enable),
            .scoring    (scoring),
            .query_load (query_load),
            .query_word (query_bases[i]),
            .column_in  (col_chain[i]),
            .link_in    (link_chain[i]),
            .column_out (col_chain[i+1]),
            .link_out   (link_chain[i+1]),
            .trace      (cell_trace[i])
        );
    end

    //////////////////////////////
    // last row results
    //////////////////////////////
    assign h_last     = link_chain[Q_CELLS].h;
    assign best_score = link_chain[Q_CELLS].best;          // final at done
    assign best_index = link_chain[Q_CELLS].best_index;
    assign trace      = cell_trace[Q_CELLS-1];
    assign done       = col_chain[Q_CELLS].end_target;     // one enabled cycle wide

endmodule : sw_array

/* tests/sw_tb_cases.svh */
// alignment cases; bases are A/C/G/T only, queries up to Q_CELLS bases, targets up to MAX_T bases

localparam int N_CASES = 5;
localparam int MAX_T   = 16;    // longest target the reference model holds

//////////////////////////////
// query and target strings
//////////////////////////////
// row i of the matrix is query base i, a short query leaves the lower cells disabled
string case_query [N_CASES] = '{
    "ACGTACGT",     // exact match
    "ACGTACGT",     // one mismatch in the middle
    "ACGTACGT",     // target lacks a base, gap in target
    "ACG",          // short query, rows 3..7 pass through
    "CATGCATG"      // extra target base, heavier weights
};

int case_qlen [N_CASES] = '{8, 8, 8, 3, 8};

string case_target [N_CASES] = '{
    "ACGTACGT",
    "ACGAACGT",
    "ACGACGT",
    "TACGA",
    "CATTGCATG"
};

//////////////////////////////
// weights
//////////////////////////////
int case_match    [N_CASES] = '{2, 2, 2, 2, 3};
int case_mismatch [N_CASES] = '{-1, -1, -1, -1, -2};
int case_gap      [N_CASES] = '{-1, -1, -1, -1, -2};

//////////////////////////////
// hand-worked results at done
//////////////////////////////
// 8 x 2 on the full diagonal
// 6 + (-1) + 4 x 2 on the diagonal
// ACG = 6, query T skipped -1, ACGT +8
// ACG at cols 1..3, ties in the copied rows keep row 2
// CAT = 9, gap -2, GCATG +15
int case_best  [N_CASES] = '{16, 13, 13, 6, 22};
int case_index [N_CASES] = '{7, 7, 7, 2, 7};

/* tests/sw_array_tb.sv */
// testbench for sw_array; stops at the first mismatch, scores in the table stay far below wrap
`timescale 1ns/1ps

module sw_array_tb;

    import sw_score_pkg::*;
    import sw_array_pkg::*;

    `include "sw_tb_cases.svh"

    localparam int MAX_STALL = 2;   // longest random stall, in cycles

    logic                       clk;
    logic                       rst;
    logic                       enable;
    logic                       query_load;
    scoring_t                   scoring;
    query_t [Q_CELLS-1:0]       query_bases;
    column_t                    column;
    score_t                     h_last;
    score_t                     best_score;
    qpos_t                      best_index;
    trace_e                     trace;
    logic                       done;

    int     mh [Q_CELLS][MAX_T];    // expected H per row and column
    trace_e mt [Q_CELLS][MAX_T];    // expected trace per row and column
    int     model_best;
    int     model_row;              // smallest row holding model_best
    bit     stall_on;               // second pass drops enable at random

    sw_array u_dut (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .scoring     (scoring),
        .query_load  (query_load),
        .query_bases (query_bases),
        .column      (column),
        .h_last      (h_last),
        .best_score  (best_score),
        .best_index  (best_index),
        .trace       (trace),
        .done        (done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    //////////////////////////////
    // compare tasks
    //////////////////////////////
    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_score(input string name, input score_t got, input score_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_index(input string name, input qpos_t got, input qpos_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_trace(input string name, input trace_e got, input trace_e exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %s, expected %s", $time, name, got.name(),
                     exp.name());
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic base_t to_base(input byte ch);
        case (ch)
            "A": return base_t'(0);
            "C": return base_t'(1);
            "G": return base_t'(2);
            default: return base_t'(3);     // T
        endcase
    endfunction

    //////////////////////////////
    // reference model
    //////////////////////////////
    // local recurrence with linear gaps, row -1 and column -1 are zero
    task automatic build_model(input int c);
        string  q;
        string  t;
        int     hup;
        int     hdiag;
        int     hleft;
        int     d;
        int     e;
        int     f;
        int     g;
        trace_e gt;
        q = case_query[c];
        t = case_target[c];
        model_best = 0;
        model_row  = 0;
        for (int j = 0; j < t.len(); j++) begin
            for (int r = 0; r < Q_CELLS; r++) begin
                hup   = (r == 0) ? 0 : mh[r-1][j];
                hdiag = (r == 0 || j == 0) ? 0 : mh[r-1][j-1];
                hleft = (j == 0) ? 0 : mh[r][j-1];
                if (r >= case_qlen[c]) begin
                    mh[r][j] = hup;     // disabled row copies the row above
                    mt[r][j] = TB_H;
                end else begin
                    d = hdiag + ((q[r] == t[j]) ? case_match[c] : case_mismatch[c]);
                    e = (hleft + case_gap[c] < 0) ? 0 : hleft + case_gap[c];
                    f = (hup + case_gap[c] < 0) ? 0 : hup + case_gap[c];
                    if (f > e) begin
                        g  = f;
                        gt = TB_F;
                    end else begin
                        g  = e;
                        gt = TB_E;
                    end
                    mh[r][j] = (d >= g) ? d : g;
                    mt[r][j] = (d >= g) ? TB_H : gt;
                end
                if (mh[r][j] > model_best || (mh[r][j] == model_best && r < model_row)) begin
                    model_best = mh[r][j];
                    model_row  = r;
                end
            end
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////
    // k counts columns at the last row: 0 is the marker, 1..len the bases
    task automatic check_step(input int c, input int k, input int len);
        if (k == 0) begin
            check_score("h_last", h_last, '0);
        end else if (k >= 1 && k <= len) begin
            check_score("h_last", h_last, score_t'(mh[Q_CELLS-1][k-1]));
        end
        if (k >= 1 && k <= len) begin
            check_trace("trace", trace, mt[Q_CELLS-1][k-1]);
        end else begin
            check_trace("trace", trace, TB_NONE);
        end
        check_flag("done", done, k == len);
        if (k == len) begin
            check_score("best_score", best_score, score_t'(case_best[c]));
            check_score("best_score", best_score, score_t'(model_best));
            check_index("best_index", best_index, qpos_t'(case_index[c]));
            check_index("best_index", best_index, qpos_t'(model_row));
        end
    endtask

    task automatic run_case(input int c);
        string   t;
        int      len;
        int      n;
        column_t col;
        t   = case_target[c];
        len = t.len();
        build_model(c);
        scoring = '{match: score_t'(case_match[c]), mismatch: score_t'(case_mismatch[c]),
                    gap_open: score_t'(case_gap[c])};
        for (int i = 0; i < Q_CELLS; i++) begin
            query_bases[i] = '0;
            if (i < case_qlen[c]) begin
                query_bases[i].base = to_base(case_query[c][i]);
                query_bases[i].en   = 1'b1;
            end
        end
        enable     = 1'b1;
        query_load = 1'b1;
        column     = '0;
        @(negedge clk);
        query_load = 1'b0;
        for (int s = 0; s < len + Q_CELLS + 2; s++) begin
            check_step(c, s - Q_CELLS, len);
            col = '0;
            if (s == 0) begin
                col.new_target = 1'b1;
            end else if (s <= len) begin
                col.base       = to_base(t[s-1]);
                col.end_target = (s == len);
            end
            enable = 1'b1;
            column = col;
            @(negedge clk);
            if (stall_on && ($urandom % 4) == 0) begin
                n      = 1 + ($urandom % MAX_STALL);
                enable = 1'b0;
                column = column_t'($urandom);   // must be ignored while stalled
                repeat (n) @(negedge clk);
            end
        end
    endtask

    initial begin
        void'($urandom(12));
        rst         = 1'b1;
        enable      = 1'b0;
        query_load  = 1'b0;
        scoring     = '0;
        query_bases = '0;
        column      = '0;
        stall_on    = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        check_flag("done", done, 1'b0);
        check_trace("trace", trace, TB_NONE);
        for (int c = 0; c < N_CASES; c++) begin
            run_case(c);
        end
        stall_on = 1'b1;    // same cases again with enable gaps
        for (int c = 0; c < N_CASES; c++) begin
            run_case(c);
        end
        $display("Test passed");
        $finish;
    end

    //////////////////////////////
    // watchdog
    //////////////////////////////
    // two passes, each cycle may grow by MAX_STALL stall cycles
    initial begin
        int budget;
        budget = 0;
        for (int c = 0; c < N_CASES; c++) begin
            budget += case_target[c].len() + Q_CELLS + 4;
        end
        budget = 2 * 2 * budget * (1 + MAX_STALL) + 8;
        repeat (budget) @(posedge clk);
        $display("watchdog expired after %0d cycles without reaching the end", budget);
        abort_run();
    end

endmodule : sw_array_tb

/* files.f */
logic/sw_score_pkg.sv
logic/sw_array_pkg.sv
logic/sw_cell_score.sv
logic/sw_local_max.sv
logic/sw_cell.sv
logic/sw_array.sv
tests/sw_array_tb.sv
+incdir+tests

/* run.sh */
#!/usr/bin/env bash
# build and run the testbench, exit status follows the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f files.f --top-module sw_array_tb -o sw_sim || exit 1
out=$(./obj_dir/sw_sim)
echo "$out"
echo "$out" | grep -q "^Test passed$" && exit 0 || exit 1
